//--- hw/riscv_timer_defs.svh
`ifndef RISCV_TIMER_DEFS_SVH
`define RISCV_TIMER_DEFS_SVH

// address map of the core data port.
// both timer registers sit at the usual CLINT offsets for hart 0.
`define RISCV_MTIMECMP_ADDR   32'h0200_4000
`define RISCV_MTIME_ADDR      32'h0200_BFF8

// the data memory starts here and spans RISCV_DMEM_DEPTH doublewords.
`define RISCV_DMEM_BASE       32'h8000_0000

// number of doublewords in the data memory, a power of two.
`define RISCV_DMEM_DEPTH      64

// register select codes seen by the timer block.
// code zero selects nothing and reads back as zero.
`define RISCV_REGSEL_MTIME    2'd1
`define RISCV_REGSEL_MTIMECMP 2'd2

`endif

//--- hw/riscv_timer_pkg.sv
// shared types of the timer subsystem.
package riscv_timer_pkg;

  // one data word on the core port, also the width of mtime and mtimecmp.
  typedef logic [63:0] riscv_xlen_t;

  // a byte address as issued by the core.
  typedef logic [31:0] riscv_addr_t;

  // register select from the decoder to the timer block.
  // the codes are the RISCV_REGSEL_* macros.
  typedef logic [1:0] timer_regsel_t;

endpackage

//--- hw/riscv_timer_irq.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_timer_irq (
  input  logic                          i_riscv_timer_clk,
  input  logic                          i_riscv_timer_rst,
  input  logic                          i_riscv_timer_wren,
  input  logic                          i_riscv_timer_rden,
  input  riscv_timer_pkg::timer_regsel_t i_riscv_timer_regsel,
  input  riscv_timer_pkg::riscv_xlen_t  i_riscv_timer_wdata,
  output riscv_timer_pkg::riscv_xlen_t  o_riscv_timer_rdata,
  output riscv_timer_pkg::riscv_xlen_t  o_riscv_timer_time,
  output logic                          o_riscv_timer_irq
);

  import riscv_timer_pkg::*;

  riscv_xlen_t mtime;
  riscv_xlen_t mtimecmp;

  logic wr_mtime;
  logic wr_mtimecmp;

  assign wr_mtime    = i_riscv_timer_wren && (i_riscv_timer_regsel == `RISCV_REGSEL_MTIME);
  assign wr_mtimecmp = i_riscv_timer_wren && (i_riscv_timer_regsel == `RISCV_REGSEL_MTIMECMP);

  // mtime runs freely, a write replaces the increment on that edge.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin
    if (i_riscv_timer_rst)
      mtime <= '0;
    else if (wr_mtime)
      mtime <= i_riscv_timer_wdata;
    else
      mtime <= mtime + riscv_xlen_t'(1);
  end

  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin
    if (i_riscv_timer_rst)
      mtimecmp <= '0;
    else if (wr_mtimecmp)
      mtimecmp <= i_riscv_timer_wdata;
  end

  assign o_riscv_timer_time = mtime;

  // a zero compare value means the interrupt is disarmed.
  assign o_riscv_timer_irq = (mtimecmp != '0) && (mtime >= mtimecmp);

  always_comb
  begin
    o_riscv_timer_rdata = '0;
    if (i_riscv_timer_rden)
    begin
      case (i_riscv_timer_regsel)
        `RISCV_REGSEL_MTIME:    o_riscv_timer_rdata = mtime;
        `RISCV_REGSEL_MTIMECMP: o_riscv_timer_rdata = mtimecmp;
        default:                o_riscv_timer_rdata = '0;
      endcase
    end
  end

endmodule

//--- hw/riscv_dmem.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_dmem #(
  parameter int DEPTH = `RISCV_DMEM_DEPTH
) (
  input  logic                         i_riscv_timer_clk,
  input  logic                         i_riscv_timer_rst,
  input  logic                         i_riscv_dmem_wren,
  input  logic                         i_riscv_dmem_rden,
  input  logic [$clog2(DEPTH)-1:0]     i_riscv_dmem_index,
  input  riscv_timer_pkg::riscv_xlen_t i_riscv_dmem_wdata,
  output riscv_timer_pkg::riscv_xlen_t o_riscv_dmem_rdata
);

  import riscv_timer_pkg::*;

  riscv_xlen_t mem [DEPTH];

  // the whole array clears on reset so that every word reads zero afterwards.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin
    if (i_riscv_timer_rst)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
    end
    else if (i_riscv_dmem_wren)
    begin
      mem[i_riscv_dmem_index] <= i_riscv_dmem_wdata;
    end
  end

  // combinational read, zero while no read is active.
  always_comb
  begin
    if (i_riscv_dmem_rden)
      o_riscv_dmem_rdata = mem[i_riscv_dmem_index];
    else
      o_riscv_dmem_rdata = '0;
  end

endmodule

//--- hw/riscv_mmio_decode.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_mmio_decode (
  input  riscv_timer_pkg::riscv_addr_t   i_riscv_timer_addr,
  input  logic                           i_riscv_timer_wren,
  input  logic                           i_riscv_timer_rden,
  input  riscv_timer_pkg::riscv_xlen_t   i_riscv_timer_tmr_rdata,
  input  riscv_timer_pkg::riscv_xlen_t   i_riscv_timer_mem_rdata,
  output logic                           o_riscv_timer_tmr_wren,
  output logic                           o_riscv_timer_tmr_rden,
  output logic                           o_riscv_timer_mem_wren,
  output logic                           o_riscv_timer_mem_rden,
  output riscv_timer_pkg::timer_regsel_t o_riscv_timer_tmr_regsel,
  output logic [$clog2(`RISCV_DMEM_DEPTH)-1:0] o_riscv_timer_mem_index,
  output riscv_timer_pkg::riscv_xlen_t   o_riscv_timer_rdata,
  output logic                           o_riscv_timer_fault
);

  import riscv_timer_pkg::*;

  localparam int MEM_AW = $clog2(`RISCV_DMEM_DEPTH);

  // size of the memory region in bytes.
  localparam riscv_addr_t MEM_BYTES = riscv_addr_t'(`RISCV_DMEM_DEPTH * 8);

  riscv_addr_t mem_offset;

  logic hit_mtime;
  logic hit_mtimecmp;
  logic hit_tmr;
  logic hit_mem;
  logic access;

  assign hit_mtime    = (i_riscv_timer_addr == `RISCV_MTIME_ADDR);
  assign hit_mtimecmp = (i_riscv_timer_addr == `RISCV_MTIMECMP_ADDR);
  assign hit_tmr      = hit_mtime || hit_mtimecmp;

  // the subtraction wraps below the base, so one compare covers both bounds.
  // only doubleword aligned addresses map onto a memory word.
  assign mem_offset = i_riscv_timer_addr - riscv_addr_t'(`RISCV_DMEM_BASE);
  assign hit_mem    = (mem_offset < MEM_BYTES) && (i_riscv_timer_addr[2:0] == 3'b000);

  assign access = i_riscv_timer_wren || i_riscv_timer_rden;

  assign o_riscv_timer_tmr_wren = i_riscv_timer_wren && hit_tmr;
  assign o_riscv_timer_tmr_rden = i_riscv_timer_rden && hit_tmr;
  assign o_riscv_timer_mem_wren = i_riscv_timer_wren && hit_mem;
  assign o_riscv_timer_mem_rden = i_riscv_timer_rden && hit_mem;

  always_comb
  begin
    if (hit_mtime)
      o_riscv_timer_tmr_regsel = `RISCV_REGSEL_MTIME;
    else if (hit_mtimecmp)
      o_riscv_timer_tmr_regsel = `RISCV_REGSEL_MTIMECMP;
    else
      o_riscv_timer_tmr_regsel = '0;
  end

  // word index within the memory, byte offset bits dropped.
  assign o_riscv_timer_mem_index = mem_offset[MEM_AW+2:3];

  // read data comes back from whichever block was selected this cycle.
  always_comb
  begin
    if (o_riscv_timer_tmr_rden)
      o_riscv_timer_rdata = i_riscv_timer_tmr_rdata;
    else if (o_riscv_timer_mem_rden)
      o_riscv_timer_rdata = i_riscv_timer_mem_rdata;
    else
      o_riscv_timer_rdata = '0;
  end

  // unmapped accesses raise the fault for the cycle of the strobe.
  assign o_riscv_timer_fault = access && !hit_tmr && !hit_mem;

endmodule

//--- hw/riscv_timer_subsys.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_timer_subsys (
  input  logic                         i_riscv_timer_clk,
  input  logic                         i_riscv_timer_rst,
  input  riscv_timer_pkg::riscv_addr_t i_riscv_timer_addr,
  input  logic                         i_riscv_timer_wren,
  input  logic                         i_riscv_timer_rden,
  input  riscv_timer_pkg::riscv_xlen_t i_riscv_timer_wdata,
  output riscv_timer_pkg::riscv_xlen_t o_riscv_timer_rdata,
  output riscv_timer_pkg::riscv_xlen_t o_riscv_timer_time,
  output logic                         o_riscv_timer_irq,
  output logic                         o_riscv_timer_fault
);

  import riscv_timer_pkg::*;

  logic                                tmr_wren;
  logic                                tmr_rden;
  timer_regsel_t                       tmr_regsel;
  riscv_xlen_t                         tmr_rdata;
  logic                                mem_wren;
  logic                                mem_rden;
  logic [$clog2(`RISCV_DMEM_DEPTH)-1:0] mem_index;
  riscv_xlen_t                         mem_rdata;

  // the decoder is the only block that looks at the address.
  riscv_mmio_decode u_decode (
    .i_riscv_timer_addr       (i_riscv_timer_addr),
    .i_riscv_timer_wren       (i_riscv_timer_wren),
    .i_riscv_timer_rden       (i_riscv_timer_rden),
    .i_riscv_timer_tmr_rdata  (tmr_rdata),
    .i_riscv_timer_mem_rdata  (mem_rdata),
    .o_riscv_timer_tmr_wren   (tmr_wren),
    .o_riscv_timer_tmr_rden   (tmr_rden),
    .o_riscv_timer_mem_wren   (mem_wren),
    .o_riscv_timer_mem_rden   (mem_rden),
    .o_riscv_timer_tmr_regsel (tmr_regsel),
    .o_riscv_timer_mem_index  (mem_index),
    .o_riscv_timer_rdata      (o_riscv_timer_rdata),
    .o_riscv_timer_fault      (o_riscv_timer_fault)
  );

  riscv_timer_irq u_timer (
    .i_riscv_timer_clk    (i_riscv_timer_clk),
    .i_riscv_timer_rst    (i_riscv_timer_rst),
    .i_riscv_timer_wren   (tmr_wren),
    .i_riscv_timer_rden   (tmr_rden),
    .i_riscv_timer_regsel (tmr_regsel),
    .i_riscv_timer_wdata  (i_riscv_timer_wdata),
    .o_riscv_timer_rdata  (tmr_rdata),
    .o_riscv_timer_time   (o_riscv_timer_time),
    .o_riscv_timer_irq    (o_riscv_timer_irq)
  );

  // write data is shared, only the strobes differ between the two blocks.
  riscv_dmem #(
    .DEPTH (`RISCV_DMEM_DEPTH)
  ) u_dmem (
    .i_riscv_timer_clk  (i_riscv_timer_clk),
    .i_riscv_timer_rst  (i_riscv_timer_rst),
    .i_riscv_dmem_wren  (mem_wren),
    .i_riscv_dmem_rden  (mem_rden),
    .i_riscv_dmem_index (mem_index),
    .i_riscv_dmem_wdata (i_riscv_timer_wdata),
    .o_riscv_dmem_rdata (mem_rdata)
  );

endmodule

//--- dv/riscv_timer_subsys_props.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_timer_subsys_props (
  input  logic                           i_riscv_timer_clk,
  input  logic                           i_riscv_timer_rst,
  input  logic                           i_riscv_timer_wren,
  input  logic                           i_riscv_timer_rden,
  input  riscv_timer_pkg::timer_regsel_t i_riscv_timer_regsel,
  input  riscv_timer_pkg::riscv_xlen_t   i_riscv_timer_wdata,
  input  riscv_timer_pkg::riscv_xlen_t   i_riscv_timer_rdata,
  input  riscv_timer_pkg::riscv_xlen_t   i_riscv_timer_time,
  input  logic                           i_riscv_timer_irq
);

  import riscv_timer_pkg::*;

  // number of assertion failures seen in this instance.
  int unsigned assert_errors = 0;

  riscv_xlen_t cmp_seen;

  logic wr_mtime;
  logic wr_mtimecmp;

  assign wr_mtime    = i_riscv_timer_wren && (i_riscv_timer_regsel == `RISCV_REGSEL_MTIME);
  assign wr_mtimecmp = i_riscv_timer_wren && (i_riscv_timer_regsel == `RISCV_REGSEL_MTIMECMP);

  // compare value as last written through the strobes.
  always_ff @(posedge i_riscv_timer_clk or posedge i_riscv_timer_rst)
  begin
    if (i_riscv_timer_rst)
      cmp_seen <= '0;
    else if (wr_mtimecmp)
      cmp_seen <= i_riscv_timer_wdata;
  end

  irq_follows_compare: assert property (@(posedge i_riscv_timer_clk)
    disable iff (i_riscv_timer_rst)
    i_riscv_timer_irq == ((cmp_seen != '0) && (i_riscv_timer_time >= cmp_seen)))
  else
  begin
    $error("interrupt level does not match the mtimecmp compare");
    assert_errors++;
  end

  // the sampled reset keeps the edge that releases reset out of the check.
  mtime_counts_up: assert property (@(posedge i_riscv_timer_clk)
    disable iff (i_riscv_timer_rst)
    (!i_riscv_timer_rst && !wr_mtime) |=> (i_riscv_timer_time == $past(i_riscv_timer_time) + 64'd1))
  else
  begin
    $error("mtime did not advance by one without a write");
    assert_errors++;
  end

  rdata_idle_zero: assert property (@(posedge i_riscv_timer_clk)
    disable iff (i_riscv_timer_rst)
    !i_riscv_timer_rden |-> (i_riscv_timer_rdata == '0))
  else
  begin
    $error("timer read data is nonzero without a read strobe");
    assert_errors++;
  end

endmodule

bind riscv_timer_irq riscv_timer_subsys_props u_props (
  .i_riscv_timer_clk      (i_riscv_timer_clk),
  .i_riscv_timer_rst      (i_riscv_timer_rst),
  .i_riscv_timer_wren     (i_riscv_timer_wren),
  .i_riscv_timer_rden     (i_riscv_timer_rden),
  .i_riscv_timer_regsel   (i_riscv_timer_regsel),
  .i_riscv_timer_wdata    (i_riscv_timer_wdata),
  .i_riscv_timer_rdata    (o_riscv_timer_rdata),
  .i_riscv_timer_time     (o_riscv_timer_time),
  .i_riscv_timer_irq      (o_riscv_timer_irq)
);

//--- dv/riscv_timer_subsys_tb.sv
`timescale 1ns/1ps

`include "riscv_timer_defs.svh"

module riscv_timer_subsys_tb;

  import riscv_timer_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int MARGIN       = 50;
  localparam int NUM_TESTS    = 6;

  localparam riscv_addr_t MEM_BASE = `RISCV_DMEM_BASE;
  localparam riscv_addr_t MEM_END  = `RISCV_DMEM_BASE + `RISCV_DMEM_DEPTH * 8;
  localparam riscv_addr_t MEM_LAST = MEM_END - 32'd8;
  localparam riscv_addr_t MTIME    = `RISCV_MTIME_ADDR;
  localparam riscv_addr_t MTIMECMP = `RISCV_MTIMECMP_ADDR;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE, OP_IRQ} op_e;

  // model takes the value from the reference model, the others name a fixed outcome.
  typedef enum logic [1:0] {EXP_MODEL, EXP_LOW, EXP_HIGH, EXP_FAULT} exp_e;

  // for an idle entry the data field holds the number of cycles.
  typedef struct packed {
    op_e         op;
    riscv_addr_t addr;
    riscv_xlen_t data;
    exp_e        kind;
    logic [3:0]  test_id;
  } step_t;

  logic        clk;
  logic        rst;
  riscv_addr_t addr;
  logic        wren;
  logic        rden;
  riscv_xlen_t wdata;
  riscv_xlen_t rdata;
  riscv_xlen_t mtime_out;
  logic        irq;
  logic        fault;

  step_t       table_q[$];
  string       test_name [1:NUM_TESTS];
  logic [3:0]  cur_test;
  int          total_cycles;
  logic        table_ready = 1'b0;

  riscv_xlen_t rng_state;
  riscv_xlen_t model_mem [`RISCV_DMEM_DEPTH];
  riscv_xlen_t model_cmp;
  riscv_xlen_t model_mt_base;
  logic [63:0] model_mt_cycle;
  logic [63:0] cyc_count = '0;

  int error_count;
  int check_count;
  int errors_at_start;
  int tests_passed;
  int tests_failed;
  int assert_fails;

  riscv_timer_subsys uut (
    .i_riscv_timer_clk   (clk),
    .i_riscv_timer_rst   (rst),
    .i_riscv_timer_addr  (addr),
    .i_riscv_timer_wren  (wren),
    .i_riscv_timer_rden  (rden),
    .i_riscv_timer_wdata (wdata),
    .o_riscv_timer_rdata (rdata),
    .o_riscv_timer_time  (mtime_out),
    .o_riscv_timer_irq   (irq),
    .o_riscv_timer_fault (fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // edge count, read at the falling edge where it is stable.
  always @(posedge clk)
    cyc_count <= cyc_count + 64'd1;

  function automatic riscv_xlen_t xorshift64(input riscv_xlen_t s);
    riscv_xlen_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic riscv_xlen_t next_word();
    rng_state = xorshift64(rng_state);
    return rng_state;
  endfunction

  function automatic logic in_memory(input riscv_addr_t a);
    return (a >= MEM_BASE) && (a < MEM_END) && (a[2:0] == 3'b000);
  endfunction

  function automatic int mem_word(input riscv_addr_t a);
    return int'((a - MEM_BASE) >> 3);
  endfunction

  function automatic logic is_mapped(input riscv_addr_t a);
    return (a == MTIME) || (a == MTIMECMP) || in_memory(a);
  endfunction

  // mtime counts one per edge from the last value written into it.
  function automatic riscv_xlen_t model_time();
    return model_mt_base + (cyc_count - model_mt_cycle);
  endfunction

  function automatic riscv_xlen_t model_read(input riscv_addr_t a);
    if (a == MTIME)
      return model_time();
    else if (a == MTIMECMP)
      return model_cmp;
    else if (in_memory(a))
      return model_mem[mem_word(a)];
    return '0;
  endfunction

  // called at the falling edge, the DUT takes the write at the next rising edge.
  task automatic model_write(input riscv_addr_t a, input riscv_xlen_t d);
    if (a == MTIME)
    begin
      model_mt_base  = d;
      model_mt_cycle = cyc_count + 64'd1;
    end
    else if (a == MTIMECMP)
      model_cmp = d;
    else if (in_memory(a))
      model_mem[mem_word(a)] = d;
  endtask

  task automatic check_value(input string name, input riscv_xlen_t exp, input riscv_xlen_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("Fail %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_outputs(input step_t s);
    riscv_xlen_t exp_time;
    riscv_xlen_t exp_rdata;
    logic        exp_irq;
    logic        exp_fault;
    exp_time  = model_time();
    exp_irq   = (model_cmp != '0) && (exp_time >= model_cmp);
    exp_fault = ((s.op == OP_WRITE) || (s.op == OP_READ)) && !is_mapped(s.addr);
    exp_rdata = (s.op == OP_READ) ? model_read(s.addr) : '0;
    check_value("o_riscv_timer_time", exp_time, mtime_out);
    check_value("o_riscv_timer_irq", riscv_xlen_t'(exp_irq), riscv_xlen_t'(irq));
    check_value("o_riscv_timer_fault", riscv_xlen_t'(exp_fault), riscv_xlen_t'(fault));
    check_value("o_riscv_timer_rdata", exp_rdata, rdata);
    if ((s.kind == EXP_LOW) || (s.kind == EXP_HIGH))
      check_value("o_riscv_timer_irq", riscv_xlen_t'(s.kind == EXP_HIGH), riscv_xlen_t'(irq));
    if (s.kind == EXP_FAULT)
      check_value("o_riscv_timer_fault", 64'd1, riscv_xlen_t'(fault));
  endtask

  task automatic apply_entry(input step_t s);
    int cycles;
    cycles = (s.op == OP_IDLE) ? int'(s.data) : 1;
    for (int i = 0; i < cycles; i++)
    begin
      @(posedge clk);
      wren  <= (s.op == OP_WRITE);
      rden  <= (s.op == OP_READ);
      addr  <= ((s.op == OP_WRITE) || (s.op == OP_READ)) ? s.addr : '0;
      wdata <= (s.op == OP_WRITE) ? s.data : '0;
      @(negedge clk);
      check_outputs(s);
      if (s.op == OP_WRITE)
        model_write(s.addr, s.data);
    end
  endtask

  task automatic start_test(input int n, input string name);
    cur_test     = 4'(n);
    test_name[n] = name;
  endtask

  task automatic add_entry(input op_e op, input riscv_addr_t a, input riscv_xlen_t d,
                           input exp_e kind);
    step_t s;
    s.op      = op;
    s.addr    = a;
    s.data    = d;
    s.kind    = kind;
    s.test_id = cur_test;
    table_q.push_back(s);
    total_cycles += (op == OP_IDLE) ? int'(d) : 1;
  endtask

  task automatic build_table();
    start_test(1, "reset values");
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);
    add_entry(OP_READ, MTIMECMP, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h100, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_LAST, '0, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);
    add_entry(OP_IDLE, '0, 64'd2, EXP_MODEL);

    start_test(2, "memory write and read back");
    add_entry(OP_WRITE, MEM_BASE, next_word(), EXP_MODEL);
    add_entry(OP_WRITE, MEM_BASE + 32'h8, next_word(), EXP_MODEL);
    add_entry(OP_WRITE, MEM_BASE + 32'h100, next_word(), EXP_MODEL);
    add_entry(OP_WRITE, MEM_LAST, next_word(), EXP_MODEL);
    add_entry(OP_READ, MEM_BASE, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h8, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h100, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_LAST, '0, EXP_MODEL);
    add_entry(OP_WRITE, MTIME, next_word(), EXP_MODEL);
    add_entry(OP_READ, MEM_BASE, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h8, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h100, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_LAST, '0, EXP_MODEL);

    start_test(3, "mtime write and count");
    add_entry(OP_WRITE, MTIME, next_word(), EXP_MODEL);
    add_entry(OP_IDLE, '0, 64'd5, EXP_MODEL);
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);
    add_entry(OP_IDLE, '0, 64'd1, EXP_MODEL);
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);

    // mtime reads 0x1001 on the first check and reaches 0x1008 seven cycles later.
    start_test(4, "interrupt compare");
    add_entry(OP_WRITE, MTIME, 64'h1000, EXP_MODEL);
    add_entry(OP_WRITE, MTIMECMP, 64'h1008, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);
    add_entry(OP_IDLE, '0, 64'd5, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);
    add_entry(OP_IRQ, '0, '0, EXP_HIGH);
    add_entry(OP_IDLE, '0, 64'd3, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_HIGH);
    add_entry(OP_READ, MTIMECMP, '0, EXP_MODEL);
    add_entry(OP_WRITE, MTIMECMP, 64'h8000, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);

    start_test(5, "disarmed compare");
    add_entry(OP_WRITE, MTIMECMP, '0, EXP_MODEL);
    add_entry(OP_WRITE, MTIME, 64'hFFFF_FFFF_FFFF_FF00, EXP_MODEL);
    add_entry(OP_IDLE, '0, 64'd4, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);
    add_entry(OP_WRITE, MTIME, 64'h7FFF_FFFF_FFFF_FFFF, EXP_MODEL);
    add_entry(OP_IDLE, '0, 64'd2, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);

    start_test(6, "unmapped access");
    add_entry(OP_WRITE, MTIMECMP, 64'hFFFF_0000_0000_0000, EXP_MODEL);
    add_entry(OP_READ, 32'h1000_0000, '0, EXP_FAULT);
    add_entry(OP_WRITE, MTIMECMP + 32'h8, next_word(), EXP_FAULT);
    add_entry(OP_WRITE, MEM_END, next_word(), EXP_FAULT);
    add_entry(OP_WRITE, MEM_BASE - 32'h8, next_word(), EXP_FAULT);
    add_entry(OP_READ, MTIME - 32'h8, '0, EXP_FAULT);
    add_entry(OP_WRITE, 32'h0000_0000, next_word(), EXP_FAULT);
    add_entry(OP_READ, MTIMECMP, '0, EXP_MODEL);
    add_entry(OP_READ, MTIME, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_BASE + 32'h8, '0, EXP_MODEL);
    add_entry(OP_READ, MEM_LAST, '0, EXP_MODEL);
    add_entry(OP_IRQ, '0, '0, EXP_LOW);
  endtask

  task automatic report_test(input int n);
    int errs;
    errs = error_count - errors_at_start;
    if (errs == 0)
    begin
      tests_passed++;
      $display("test %0d %s: ok", n, test_name[n]);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", n, test_name[n], errs);
    end
    errors_at_start = error_count;
  endtask

  initial
  begin
    rst             = 1'b1;
    wren            = 1'b0;
    rden            = 1'b0;
    addr            = '0;
    wdata           = '0;
    rng_state       = 64'd38;
    model_cmp       = '0;
    model_mt_base   = '0;
    model_mt_cycle  = '0;
    error_count     = 0;
    check_count     = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    total_cycles    = 0;
    for (int i = 0; i < `RISCV_DMEM_DEPTH; i++)
      model_mem[i] = '0;
    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // the flops still see reset on the releasing edge, so mtime starts counting after it.
    model_mt_base  = '0;
    model_mt_cycle = cyc_count;

    for (int i = 0; i < table_q.size(); i++)
    begin
      apply_entry(table_q[i]);
      if ((i == table_q.size() - 1) || (table_q[i + 1].test_id != table_q[i].test_id))
        report_test(int'(table_q[i].test_id));
    end

    assert_fails = int'(uut.u_timer.u_props.assert_errors);
    $display("%0d tests: %0d ok, %0d failed; %0d checks, %0d errors, %0d assertion failures",
             NUM_TESTS, tests_passed, tests_failed, check_count, error_count, assert_fails);
    if ((error_count == 0) && (assert_fails == 0))
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // budget is the table length plus reset and a margin.
  initial
  begin
    wait (table_ready);
    #((total_cycles + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: the stimulus table did not finish within %0d cycles",
             total_cycles + RESET_CYCLES + MARGIN);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/riscv_timer_pkg.sv
hw/riscv_timer_irq.sv
hw/riscv_dmem.sv
hw/riscv_mmio_decode.sv
hw/riscv_timer_subsys.sv
dv/riscv_timer_subsys_props.sv
dv/riscv_timer_subsys_tb.sv
